//--- Makefile
# Verilator build and run of the APB subsystem testbench
# Override any variable on the command line, e.g. make TOP=... OBJ_DIR=...

VERILATOR  ?= verilator
TOP        ?= tb_apb_subsystem
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
src/apb_ss_pkg.sv
src/ahb_to_apb_bridge.sv
src/apb_slave_mux.sv
src/apb_gpio.sv
src/apb_timer.sv
src/apb_subsystem_top.sv
verif/tb_clk_gen.sv
verif/tb_apb_subsystem.sv

//--- src/ahb_to_apb_bridge.sv
// Single transfers only, one in flight; non-word hsize gets ERROR without APB
// hwdata must be held by the master for its whole data phase
`timescale 1ns/1ps

module ahb_to_apb_bridge (
  input  logic                          tb_hclk13,
  input  logic                          hresetn13,
  input  logic                          i_hsel,
  input  apb_ss_pkg::ahb_req_t          i_ahb_req,
  input  logic [apb_ss_pkg::DATA_W-1:0] i_hwdata,
  output logic [apb_ss_pkg::DATA_W-1:0] o_hrdata,
  output logic                          o_hready,
  output logic                          o_hresp,    // 1 = ERROR
  output logic                          o_psel,
  output apb_ss_pkg::apb_req_t          o_apb_req,
  input  apb_ss_pkg::apb_rsp_t          i_apb_rsp
);
  import apb_ss_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_SETUP, ST_ACCESS, ST_ERR1, ST_ERR2} state_t;

  state_t                state_q;
  state_t                state_d;
  logic                  accept;     // Address phase taken this edge
  logic                  size_ok;
  logic [APB_ADDR_W-1:0] addr_q;     // Truncated to the APB space
  logic                  write_q;
  logic [DATA_W-1:0]     wdata_q;

  assign accept  = i_hsel && (i_ahb_req.htrans == HTRANS_NONSEQ) && o_hready;
  assign size_ok = (i_ahb_req.hsize == HSIZE_WORD);

  // ====================
  // Transfer FSM
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_ERR2: begin            // Both end with hready high
        if (accept)
          state_d = size_ok ? ST_SETUP : ST_ERR1;
        else
          state_d = ST_IDLE;
      end
      ST_SETUP:  state_d = ST_ACCESS;
      ST_ACCESS: begin
        if (i_apb_rsp.pready)            // Wait states just hold here
          state_d = i_apb_rsp.pslverr ? ST_ERR1 : ST_IDLE;
      end
      ST_ERR1:   state_d = ST_ERR2;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge tb_hclk13) begin
    if (!hresetn13)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // Address phase capture
  always_ff @(posedge tb_hclk13) begin
    if (accept) begin
      addr_q  <= i_ahb_req.haddr[APB_ADDR_W-1:0];
      write_q <= i_ahb_req.hwrite;
    end
    if (state_q == ST_SETUP)
      wdata_q <= i_hwdata;               // Held for the ACCESS cycles
    if ((state_q == ST_ACCESS) && i_apb_rsp.pready && !write_q)
      o_hrdata <= i_apb_rsp.prdata;
  end

  // ====================
  // Outputs
  // ====================
  assign o_hready = (state_q == ST_IDLE) || (state_q == ST_ERR2);
  assign o_hresp  = (state_q == ST_ERR1) || (state_q == ST_ERR2);
  assign o_psel   = (state_q == ST_SETUP) || (state_q == ST_ACCESS);

  assign o_apb_req.paddr   = addr_q;
  assign o_apb_req.pwrite  = write_q;
  assign o_apb_req.penable = (state_q == ST_ACCESS);
  assign o_apb_req.pwdata  = (state_q == ST_SETUP) ? i_hwdata : wdata_q;

  // penable never starts without a select in the cycle before
  a_penable_after_setup: assert property (@(posedge tb_hclk13) disable iff (!hresetn13)
    o_apb_req.penable |-> $past(o_psel));

  // Request frozen from SETUP through the last ACCESS cycle
  a_req_stable: assert property (@(posedge tb_hclk13) disable iff (!hresetn13)
    (state_q == ST_ACCESS) |-> ($stable(o_apb_req.paddr) && $stable(o_apb_req.pwrite)
                                && $stable(o_apb_req.pwdata)));

  // Only the second ERROR cycle shows hresp with hready high
  a_no_resp_idle: assert property (@(posedge tb_hclk13) disable iff (!hresetn13)
    (o_hready && o_hresp) |-> $past(o_hresp && !o_hready));

endmodule

//--- src/apb_gpio.sv
// Zero wait states, never reports pslverr; unknown offsets read zero
// Pin inputs pass a 2-flop synchronizer before edge detection
`timescale 1ns/1ps

module apb_gpio (
  input  logic                          tb_hclk13,
  input  logic                          hresetn13,
  input  logic                          i_psel,
  input  apb_ss_pkg::apb_req_t          i_apb_req,
  output apb_ss_pkg::apb_rsp_t          o_apb_rsp,
  input  logic [apb_ss_pkg::GPIO_W-1:0] i_gpio_in,
  output logic [apb_ss_pkg::GPIO_W-1:0] o_gpio_out,
  output logic [apb_ss_pkg::GPIO_W-1:0] o_gpio_oe,
  output logic                          o_gpio_irq
);
  import apb_ss_pkg::*;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] dir_q;
  logic [GPIO_W-1:0] mask_q;
  logic [GPIO_W-1:0] stat_q;
  logic [GPIO_W-1:0] sync1_q;    // Synchronizer stages
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;     // Last synced value, for edges
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] stat_clr;
  logic [OFS_W-1:0]  ofs;
  logic              wr_en;

  assign ofs   = i_apb_req.paddr[OFS_W-1:0];
  assign wr_en = i_psel && i_apb_req.penable && i_apb_req.pwrite;  // End of ACCESS
  assign rise  = sync2_q & ~prev_q;
  assign stat_clr = (wr_en && (ofs == GPIO_IRQ_STAT)) ? i_apb_req.pwdata[GPIO_W-1:0] : '0;

  // ====================
  // Input path
  // ====================
  always_ff @(posedge tb_hclk13) begin
    sync1_q <= i_gpio_in;
    sync2_q <= sync1_q;
    prev_q  <= sync2_q;    // Synced pins one cycle back
  end

  // Registers
  always_ff @(posedge tb_hclk13) begin
    if (!hresetn13) begin
      out_q  <= '0;
      dir_q  <= '0;
      mask_q <= '0;
      stat_q <= '0;
    end else begin
      if (wr_en && (ofs == GPIO_OUT))
        out_q <= i_apb_req.pwdata[GPIO_W-1:0];
      if (wr_en && (ofs == GPIO_DIR))
        dir_q <= i_apb_req.pwdata[GPIO_W-1:0];
      if (wr_en && (ofs == GPIO_IRQ_MASK))
        mask_q <= i_apb_req.pwdata[GPIO_W-1:0];
      stat_q <= (stat_q & ~stat_clr) | rise;   // New edge beats clear
    end
  end

  // Read mux
  always_comb begin
    o_apb_rsp         = '0;
    o_apb_rsp.pready  = 1'b1;
    o_apb_rsp.pslverr = 1'b0;
    case (ofs)
      GPIO_OUT:      o_apb_rsp.prdata[GPIO_W-1:0] = out_q;
      GPIO_DIR:      o_apb_rsp.prdata[GPIO_W-1:0] = dir_q;
      GPIO_IN:       o_apb_rsp.prdata[GPIO_W-1:0] = sync2_q;
      GPIO_IRQ_STAT: o_apb_rsp.prdata[GPIO_W-1:0] = stat_q;
      GPIO_IRQ_MASK: o_apb_rsp.prdata[GPIO_W-1:0] = mask_q;
      default:       o_apb_rsp.prdata = '0;
    endcase
  end

  assign o_gpio_out = out_q;
  assign o_gpio_oe  = dir_q;
  assign o_gpio_irq = |(stat_q & mask_q);

endmodule

//--- src/apb_slave_mux.sv
// Combinational decode of paddr[15:12]; regions other than GPIO and timer are unmapped
`timescale 1ns/1ps

module apb_slave_mux (
  input  logic                                i_psel,
  input  logic [apb_ss_pkg::REGION_W-1:0]     i_paddr_region,
  output logic [apb_ss_pkg::NUM_SLV-1:0]      o_psel_slv,
  input  apb_ss_pkg::apb_rsp_t                i_rsp_gpio,
  input  apb_ss_pkg::apb_rsp_t                i_rsp_timer,
  output apb_ss_pkg::apb_rsp_t                o_apb_rsp
);
  import apb_ss_pkg::*;

  logic unmapped;    // Selected, but no peripheral there

  // ====================
  // Region decode
  // ====================
  always_comb begin
    o_psel_slv = '0;
    unmapped   = 1'b0;
    if (i_psel) begin
      case (i_paddr_region)
        SLV_GPIO:  o_psel_slv[SEL_GPIO]  = 1'b1;
        SLV_TIMER: o_psel_slv[SEL_TIMER] = 1'b1;
        default:   unmapped = 1'b1;
      endcase
    end
  end

  // Response return
  always_comb begin
    o_apb_rsp = '0;                      // Idle bus reads zero, not ready
    if (o_psel_slv[SEL_GPIO])
      o_apb_rsp = i_rsp_gpio;
    else if (o_psel_slv[SEL_TIMER])
      o_apb_rsp = i_rsp_timer;
    else if (unmapped) begin
      o_apb_rsp.pready  = 1'b1;          // Answer at once with an error
      o_apb_rsp.pslverr = 1'b1;
    end
  end

endmodule

//--- src/apb_ss_pkg.sv
// One clock for AHB and APB, word accesses only
// Address bits 15:12 select the peripheral, bits 11:0 the register
package apb_ss_pkg;

  // ====================
  // Widths and address map
  // ====================
  localparam int AHB_ADDR_W = 32;
  localparam int DATA_W     = 32;
  localparam int APB_ADDR_W = 16;
  localparam int GPIO_W     = 16;
  localparam int NUM_SLV    = 2;
  localparam int REGION_W   = 4;     // Region field in paddr[15:12]
  localparam int OFS_W      = 12;    // Register offset inside a region

  localparam logic [REGION_W-1:0] SLV_GPIO  = 4'h0;
  localparam logic [REGION_W-1:0] SLV_TIMER = 4'h1;
  localparam int SEL_GPIO  = 0;      // Bit in the one-hot select
  localparam int SEL_TIMER = 1;

  // AHB encodings
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [2:0] HSIZE_WORD    = 3'b010;

  // ====================
  // Register offsets
  // ====================
  localparam logic [OFS_W-1:0] GPIO_OUT      = 12'h000;
  localparam logic [OFS_W-1:0] GPIO_DIR      = 12'h004;  // 1 = output
  localparam logic [OFS_W-1:0] GPIO_IN       = 12'h008;
  localparam logic [OFS_W-1:0] GPIO_IRQ_STAT = 12'h00C;  // Write 1 to clear
  localparam logic [OFS_W-1:0] GPIO_IRQ_MASK = 12'h010;  // 1 = irq enabled
  localparam logic [OFS_W-1:0] TMR_CTRL      = 12'h000;
  localparam logic [OFS_W-1:0] TMR_LOAD      = 12'h004;
  localparam logic [OFS_W-1:0] TMR_COUNT     = 12'h008;  // Read only
  localparam logic [OFS_W-1:0] TMR_STAT      = 12'h00C;  // Bit 0, write 1 to clear
  localparam int TMR_EN_BIT   = 0;
  localparam int TMR_AUTO_BIT = 1;

  // AHB address phase group
  typedef struct packed {
    logic [AHB_ADDR_W-1:0] haddr;
    logic [1:0]            htrans;
    logic                  hwrite;
    logic [2:0]            hsize;
  } ahb_req_t;

  // APB request from the bridge, psel travels on its own
  typedef struct packed {
    logic [APB_ADDR_W-1:0] paddr;
    logic                  pwrite;
    logic [DATA_W-1:0]     pwdata;
    logic                  penable;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

//--- src/apb_subsystem_top.sv
// AHB-Lite slave port in front of GPIO (0x0xxx) and timer (0x1xxx)
// hsel is the only select, haddr above bit 15 is ignored
`timescale 1ns/1ps

module apb_subsystem_top (
  input  logic                          tb_hclk13,
  input  logic                          hresetn13,
  input  logic                          i_hsel,
  input  apb_ss_pkg::ahb_req_t          i_ahb_req,
  input  logic [apb_ss_pkg::DATA_W-1:0] i_hwdata,
  output logic [apb_ss_pkg::DATA_W-1:0] o_hrdata,
  output logic                          o_hready,
  output logic                          o_hresp,
  input  logic [apb_ss_pkg::GPIO_W-1:0] i_gpio_in,
  output logic [apb_ss_pkg::GPIO_W-1:0] o_gpio_out,
  output logic [apb_ss_pkg::GPIO_W-1:0] o_gpio_oe,
  output logic                          o_gpio_irq,
  output logic                          o_timer_irq
);
  import apb_ss_pkg::*;

  // ====================
  // Internal APB bus
  // ====================
  apb_req_t           apb_req;
  apb_rsp_t           apb_rsp;      // Muxed back to the bridge
  apb_rsp_t           rsp_gpio;
  apb_rsp_t           rsp_timer;
  logic               psel;
  logic [NUM_SLV-1:0] psel_slv;

  ahb_to_apb_bridge i_ahb_to_apb_bridge (
    .tb_hclk13 (tb_hclk13),
    .hresetn13 (hresetn13),
    .i_hsel    (i_hsel),
    .i_ahb_req (i_ahb_req),
    .i_hwdata  (i_hwdata),
    .o_hrdata  (o_hrdata),
    .o_hready  (o_hready),
    .o_hresp   (o_hresp),
    .o_psel    (psel),
    .o_apb_req (apb_req),
    .i_apb_rsp (apb_rsp)
  );

  apb_slave_mux i_apb_slave_mux (
    .i_psel         (psel),
    .i_paddr_region (apb_req.paddr[APB_ADDR_W-1 -: REGION_W]),  // paddr[15:12]
    .o_psel_slv     (psel_slv),
    .i_rsp_gpio     (rsp_gpio),
    .i_rsp_timer    (rsp_timer),
    .o_apb_rsp      (apb_rsp)
  );

  apb_gpio i_apb_gpio (
    .tb_hclk13  (tb_hclk13),
    .hresetn13  (hresetn13),
    .i_psel     (psel_slv[SEL_GPIO]),
    .i_apb_req  (apb_req),
    .o_apb_rsp  (rsp_gpio),
    .i_gpio_in  (i_gpio_in),
    .o_gpio_out (o_gpio_out),
    .o_gpio_oe  (o_gpio_oe),
    .o_gpio_irq (o_gpio_irq)
  );

  apb_timer i_apb_timer (
    .tb_hclk13   (tb_hclk13),
    .hresetn13   (hresetn13),
    .i_psel      (psel_slv[SEL_TIMER]),
    .i_apb_req   (apb_req),
    .o_apb_rsp   (rsp_timer),
    .o_timer_irq (o_timer_irq)
  );

endmodule

//--- src/apb_timer.sv
// Writing LOAD also reloads COUNT; a zero load never fires
// Auto-reload restarts from LOAD on the cycle the count would reach zero
`timescale 1ns/1ps

module apb_timer (
  input  logic                 tb_hclk13,
  input  logic                 hresetn13,
  input  logic                 i_psel,
  input  apb_ss_pkg::apb_req_t i_apb_req,
  output apb_ss_pkg::apb_rsp_t o_apb_rsp,
  output logic                 o_timer_irq
);
  import apb_ss_pkg::*;

  logic [1:0]        ctrl_q;     // Auto-reload, enable
  logic [DATA_W-1:0] load_q;
  logic [DATA_W-1:0] count_q;
  logic              stat_q;     // Sticky expiry flag
  logic [OFS_W-1:0]  ofs;
  logic              wr_en;
  logic              hit_zero;   // Last decrement this cycle
  logic              stat_clr;

  assign ofs      = i_apb_req.paddr[OFS_W-1:0];
  assign wr_en    = i_psel && i_apb_req.penable && i_apb_req.pwrite;
  assign hit_zero = ctrl_q[TMR_EN_BIT] && (count_q == DATA_W'(1));
  assign stat_clr = wr_en && (ofs == TMR_STAT) && i_apb_req.pwdata[0];

  // ====================
  // Counter
  // ====================
  always_ff @(posedge tb_hclk13) begin
    if (!hresetn13) begin
      ctrl_q  <= '0;
      load_q  <= '0;
      count_q <= '0;
      stat_q  <= 1'b0;
    end else begin
      if (wr_en && (ofs == TMR_CTRL))
        ctrl_q <= i_apb_req.pwdata[1:0];
      if (wr_en && (ofs == TMR_LOAD)) begin  // Software load wins
        load_q  <= i_apb_req.pwdata;
        count_q <= i_apb_req.pwdata;
      end else if (hit_zero && ctrl_q[TMR_AUTO_BIT])
        count_q <= load_q;
      else if (ctrl_q[TMR_EN_BIT] && (count_q != '0))
        count_q <= count_q - 1'b1;           // One-shot parks at zero
      stat_q <= hit_zero | (stat_q & ~stat_clr);
    end
  end

  // Read mux
  always_comb begin
    o_apb_rsp         = '0;
    o_apb_rsp.pready  = 1'b1;
    o_apb_rsp.pslverr = 1'b0;
    case (ofs)
      TMR_CTRL:  o_apb_rsp.prdata[1:0] = ctrl_q;
      TMR_LOAD:  o_apb_rsp.prdata = load_q;
      TMR_COUNT: o_apb_rsp.prdata = count_q;
      TMR_STAT:  o_apb_rsp.prdata[0] = stat_q;
      default:   o_apb_rsp.prdata = '0;
    endcase
  end

  assign o_timer_irq = stat_q;

  // Count only ever moves down from LOAD
  a_count_le_load: assert property (@(posedge tb_hclk13) disable iff (!hresetn13)
    ctrl_q[TMR_EN_BIT] |-> (count_q <= load_q));

endmodule

//--- verif/tb_apb_subsystem.sv
// Directed tests over the AHB-Lite port, one transfer in flight at a time
// Inputs change 1 ns after the rising edge and outputs are read at that point
`timescale 1ns/1ps

module tb_apb_subsystem;
  import apb_ss_pkg::*;

  localparam int          DRIVE_DLY   = 1;       // ns after the rising edge
  localparam int          CLK_PERIOD  = 100;
  localparam int          NUM_TESTS   = 6;
  localparam int          CYCLE_BOUND = 2000;    // Per test
  localparam int          XFER_LIMIT  = 50;      // Cycles for one transfer
  localparam int          POLL_MARGIN = 20;
  localparam int          SEED        = 14394;
  localparam logic [31:0] GPIO_BASE   = 32'h0000_0000;
  localparam logic [31:0] TMR_BASE    = 32'h0000_1000;
  localparam logic [1:0]  HTRANS_IDLE = 2'b00;
  localparam logic [2:0]  HSIZE_HALF  = 3'b001;

  logic              tb_hclk13;
  logic              hresetn13;
  logic              hsel;
  ahb_req_t          ahb_req;
  logic [DATA_W-1:0] hwdata;
  logic [DATA_W-1:0] hrdata;
  logic              hready;
  logic              hresp;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic              gpio_irq;
  logic              timer_irq;
  logic [GPIO_W-1:0] pins_init;   // Pin value held through reset
  int                errors = 0;
  int                checks = 0;
  int                cycle_count = 0;

  tb_clk_gen i_tb_clk_gen (
    .tb_hclk13 (tb_hclk13),
    .hresetn13 (hresetn13)
  );

  apb_subsystem_top i_apb_subsystem_top (
    .tb_hclk13   (tb_hclk13),
    .hresetn13   (hresetn13),
    .i_hsel      (hsel),
    .i_ahb_req   (ahb_req),
    .i_hwdata    (hwdata),
    .o_hrdata    (hrdata),
    .o_hready    (hready),
    .o_hresp     (hresp),
    .i_gpio_in   (gpio_in),
    .o_gpio_out  (gpio_out),
    .o_gpio_oe   (gpio_oe),
    .o_gpio_irq  (gpio_irq),
    .o_timer_irq (timer_irq)
  );

  always @(posedge tb_hclk13) cycle_count <= cycle_count + 1;

  // ====================
  // Check and wait helpers
  // ====================
  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge tb_hclk13);
    #DRIVE_DLY;
  endtask

  // ====================
  // AHB-Lite driver
  // ====================
  // One single transfer that returns once hready is back high
  task automatic run_transfer(input logic [31:0] addr, input logic write,
                              input logic [2:0] size, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic resp,
                              output logic err_first);
    int waited;
    waited    = 0;
    err_first = 1'b0;
    while (!hready) begin                  // Hold off under back-pressure
      @(posedge tb_hclk13);
      #DRIVE_DLY;
    end
    hsel           = 1'b1;                 // Address phase
    ahb_req.haddr  = addr;
    ahb_req.htrans = HTRANS_NONSEQ;
    ahb_req.hwrite = write;
    ahb_req.hsize  = size;
    @(posedge tb_hclk13);
    #DRIVE_DLY;
    hsel           = 1'b0;                 // Data phase
    ahb_req.htrans = HTRANS_IDLE;
    hwdata         = wdata;
    while (!hready && (waited < XFER_LIMIT)) begin
      if (hresp)
        err_first = 1'b1;                  // First ERROR cycle seen
      @(posedge tb_hclk13);
      #DRIVE_DLY;
      waited++;
    end
    checks++;
    assert (hready) else begin
      errors++;
      $display("transfer to 0x%0h never finished within %0d cycles", addr, XFER_LIMIT);
    end
    rdata = hrdata;
    resp  = hresp;
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        resp;
    logic        err_first;
    run_transfer(addr, 1'b1, HSIZE_WORD, data, rdata, resp, err_first);
    check_equal("o_hresp", resp, 0);
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
    logic resp;
    logic err_first;
    run_transfer(addr, 1'b0, HSIZE_WORD, 32'h0, data, resp, err_first);
    check_equal("o_hresp", resp, 0);
  endtask

  task automatic ahb_expect_error(input logic [31:0] addr, input logic write,
                                  input logic [2:0] size);
    logic [31:0] rdata;
    logic        resp;
    logic        err_first;
    run_transfer(addr, write, size, 32'hDEAD_BEEF, rdata, resp, err_first);
    check_equal("o_hresp while o_hready low", err_first, 1);
    check_equal("o_hresp at o_hready high", resp, 1);
  endtask

  task automatic read_and_check(input logic [31:0] addr, input string name,
                                input logic [31:0] exp);
    logic [31:0] data;
    ahb_read(addr, data);
    check_equal(name, data, exp);
  endtask

  // Reads TMR_STAT until bit 0 shows up or the bound runs out
  task automatic poll_timer_expiry(input int bound);
    logic [31:0] stat;
    logic        found;
    int          start;
    start = cycle_count;
    found = 1'b0;
    while (!found && ((cycle_count - start) <= bound)) begin
      ahb_read(TMR_BASE | 32'(TMR_STAT), stat);
      found = stat[0];
    end
    checks++;
    assert (found) else begin
      errors++;
      $display("timer status never set within %0d cycles", bound);
    end
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic test_reset_values();
    check_equal("o_hready", hready, 1);
    check_equal("o_hresp", hresp, 0);
    check_equal("o_gpio_irq", gpio_irq, 0);
    check_equal("o_timer_irq", timer_irq, 0);
    check_equal("o_gpio_out", gpio_out, 0);
    check_equal("o_gpio_oe", gpio_oe, 0);
    read_and_check(GPIO_BASE | 32'(GPIO_OUT), "GPIO_OUT", 0);
    read_and_check(GPIO_BASE | 32'(GPIO_DIR), "GPIO_DIR", 0);
    read_and_check(GPIO_BASE | 32'(GPIO_IN), "GPIO_IN", 32'(pins_init));
    read_and_check(GPIO_BASE | 32'(GPIO_IRQ_STAT), "GPIO_IRQ_STAT", 0);
    read_and_check(GPIO_BASE | 32'(GPIO_IRQ_MASK), "GPIO_IRQ_MASK", 0);
    read_and_check(TMR_BASE | 32'(TMR_CTRL), "TMR_CTRL", 0);
    read_and_check(TMR_BASE | 32'(TMR_LOAD), "TMR_LOAD", 0);
    read_and_check(TMR_BASE | 32'(TMR_COUNT), "TMR_COUNT", 0);
    read_and_check(TMR_BASE | 32'(TMR_STAT), "TMR_STAT", 0);
  endtask

  task automatic test_gpio_output();
    logic [31:0] out_val;
    logic [31:0] dir_val;
    repeat (4) begin
      out_val = $urandom;
      dir_val = $urandom;
      ahb_write(GPIO_BASE | 32'(GPIO_OUT), out_val);
      ahb_write(GPIO_BASE | 32'(GPIO_DIR), dir_val);
      check_equal("o_gpio_out", gpio_out, out_val[GPIO_W-1:0]);
      check_equal("o_gpio_oe", gpio_oe, dir_val[GPIO_W-1:0]);
      read_and_check(GPIO_BASE | 32'(GPIO_OUT), "GPIO_OUT", {16'h0, out_val[15:0]});
      read_and_check(GPIO_BASE | 32'(GPIO_DIR), "GPIO_DIR", {16'h0, dir_val[15:0]});
    end
  endtask

  task automatic test_gpio_input_irq();
    logic [GPIO_W-1:0] pins;
    int                pin_a;
    int                pin_b;
    pins    = GPIO_W'($urandom);
    gpio_in = pins;
    wait_cycles(4);                        // Through the synchronizer
    read_and_check(GPIO_BASE | 32'(GPIO_IN), "GPIO_IN", 32'(pins));
    gpio_in = '0;                          // All low, then clear old edges
    wait_cycles(4);
    ahb_write(GPIO_BASE | 32'(GPIO_IRQ_STAT), 32'hFFFF);
    read_and_check(GPIO_BASE | 32'(GPIO_IRQ_STAT), "GPIO_IRQ_STAT", 0);
    check_equal("o_gpio_irq", gpio_irq, 0);
    pin_a = $urandom % GPIO_W;
    pin_b = (pin_a + 1 + ($urandom % (GPIO_W - 1))) % GPIO_W;   // Never pin_a
    ahb_write(GPIO_BASE | 32'(GPIO_IRQ_MASK), 32'(1) << pin_a);
    gpio_in[pin_a] = 1'b1;                 // Rising edge on the masked-in pin
    wait_cycles(4);
    read_and_check(GPIO_BASE | 32'(GPIO_IRQ_STAT), "GPIO_IRQ_STAT", 32'(1) << pin_a);
    check_equal("o_gpio_irq", gpio_irq, 1);
    ahb_write(GPIO_BASE | 32'(GPIO_IRQ_STAT), 32'(1) << pin_a);
    read_and_check(GPIO_BASE | 32'(GPIO_IRQ_STAT), "GPIO_IRQ_STAT", 0);
    check_equal("o_gpio_irq", gpio_irq, 0);
    gpio_in[pin_b] = 1'b1;                 // Masked-out pin sets status only
    wait_cycles(4);
    read_and_check(GPIO_BASE | 32'(GPIO_IRQ_STAT), "GPIO_IRQ_STAT", 32'(1) << pin_b);
    check_equal("o_gpio_irq", gpio_irq, 0);
    ahb_write(GPIO_BASE | 32'(GPIO_IRQ_STAT), 32'(1) << pin_b);
  endtask

  task automatic test_timer_oneshot();
    logic [31:0] load;
    load = 5 + ($urandom % 20);
    ahb_write(TMR_BASE | 32'(TMR_LOAD), load);
    read_and_check(TMR_BASE | 32'(TMR_COUNT), "TMR_COUNT", load);   // Holds while disabled
    ahb_write(TMR_BASE | 32'(TMR_CTRL), 32'h1);
    poll_timer_expiry(int'(load) + POLL_MARGIN);
    check_equal("o_timer_irq", timer_irq, 1);
    read_and_check(TMR_BASE | 32'(TMR_COUNT), "TMR_COUNT", 0);
    ahb_write(TMR_BASE | 32'(TMR_STAT), 32'h1);
    check_equal("o_timer_irq", timer_irq, 0);
    read_and_check(TMR_BASE | 32'(TMR_STAT), "TMR_STAT", 0);
    ahb_write(TMR_BASE | 32'(TMR_CTRL), 32'h0);
  endtask

  task automatic test_timer_autoreload();
    logic [31:0] load;
    logic [31:0] count;
    load = 16 + ($urandom % 16);
    ahb_write(TMR_BASE | 32'(TMR_LOAD), load);
    ahb_write(TMR_BASE | 32'(TMR_CTRL), 32'h3);   // Enable plus auto-reload
    poll_timer_expiry(int'(load) + POLL_MARGIN);
    ahb_read(TMR_BASE | 32'(TMR_COUNT), count);
    checks++;
    assert (count != 0) else begin
      errors++;
      $display("timer count stayed at zero with auto-reload on");
    end
    ahb_write(TMR_BASE | 32'(TMR_STAT), 32'h1);
    poll_timer_expiry(int'(load) + POLL_MARGIN);   // Fires again
    ahb_write(TMR_BASE | 32'(TMR_CTRL), 32'h0);
    ahb_write(TMR_BASE | 32'(TMR_STAT), 32'h1);
    read_and_check(TMR_BASE | 32'(TMR_STAT), "TMR_STAT", 0);
    check_equal("o_timer_irq", timer_irq, 0);
  endtask

  task automatic test_error_responses();
    logic [31:0] val;
    val = $urandom & 32'hFFFF;
    ahb_expect_error(32'h0000_3000, 1'b1, HSIZE_WORD);         // Unmapped write
    ahb_write(GPIO_BASE | 32'(GPIO_OUT), val);
    read_and_check(GPIO_BASE | 32'(GPIO_OUT), "GPIO_OUT", val);
    ahb_expect_error(32'h0000_7004, 1'b0, HSIZE_WORD);         // Unmapped read
    read_and_check(GPIO_BASE | 32'(GPIO_OUT), "GPIO_OUT", val);
    ahb_expect_error(GPIO_BASE | 32'(GPIO_OUT), 1'b1, HSIZE_HALF);
    check_equal("o_gpio_out", gpio_out, val[GPIO_W-1:0]);      // No APB write
    read_and_check(GPIO_BASE | 32'(GPIO_OUT), "GPIO_OUT", val);
  endtask

  // ====================
  // Run control
  // ====================
  initial begin
    void'($urandom(SEED));
    hsel      = 1'b0;
    ahb_req   = '0;
    hwdata    = '0;
    pins_init = GPIO_W'($urandom);
    gpio_in   = pins_init;
    @(posedge hresetn13);
    @(posedge tb_hclk13);
    #DRIVE_DLY;
    test_reset_values();
    test_gpio_output();
    test_gpio_input_irq();
    test_timer_oneshot();
    test_timer_autoreload();
    test_error_responses();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // Watchdog allows CYCLE_BOUND cycles per test
  initial begin
    #(NUM_TESTS * CYCLE_BOUND * CLK_PERIOD);
    $display("Timeout: tests still running after %0d cycles", NUM_TESTS * CYCLE_BOUND);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Test failed");
    $finish;
  end

endmodule

//--- verif/tb_clk_gen.sv
// 100 ns clock, reset low for the first 5 rising edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic tb_hclk13,
  output logic hresetn13
);
  localparam int HALF_PERIOD  = 50;   // ns
  localparam int RESET_CYCLES = 5;

  initial begin
    tb_hclk13 = 1'b0;
    forever #(HALF_PERIOD) tb_hclk13 = ~tb_hclk13;
  end

  // Release just after an edge, like every other input
  initial begin
    hresetn13 = 1'b0;
    repeat (RESET_CYCLES) @(posedge tb_hclk13);
    #1 hresetn13 = 1'b1;
  end

endmodule
